// File: Makefile
VERILATOR ?= verilator
TOP       := decode_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

SOURCES   := $(shell cat $(FILELIST))
BINARY    := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(BINARY)

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/branch_decode.sv
`timescale 1ns/1ps

module branch_decode (
    input  decode_pkg::instr_t   instruction,
    input  decode_pkg::iq_sel_t  iq_sel,
    output decode_pkg::bru_op_t  bru_op,
    output decode_pkg::bru_imm_t bru_imm
);

    logic       is_bru;
    logic [5:0] major;

    assign is_bru = (iq_sel == decode_pkg::IQ_BRU);
    assign major = instruction[31:26];

    always_comb begin
        bru_op = decode_pkg::BRU_PCADDU;
        if (is_bru) begin
            case (major)
                decode_pkg::OPC_JIRL: bru_op = decode_pkg::BRU_JIRL;
                decode_pkg::OPC_B:    bru_op = decode_pkg::BRU_B;
                decode_pkg::OPC_BL:   bru_op = decode_pkg::BRU_BL;
                decode_pkg::OPC_BEQ:  bru_op = decode_pkg::BRU_BEQ;
                decode_pkg::OPC_BNE:  bru_op = decode_pkg::BRU_BNE;
                decode_pkg::OPC_BLT:  bru_op = decode_pkg::BRU_BLT;
                decode_pkg::OPC_BGE:  bru_op = decode_pkg::BRU_BGE;
                decode_pkg::OPC_BLTU: bru_op = decode_pkg::BRU_BLTU;
                decode_pkg::OPC_BGEU: bru_op = decode_pkg::BRU_BGEU;
                default:              bru_op = decode_pkg::BRU_PCADDU;  // PCADDU12I
            endcase
        end
    end

    always_comb begin
        if (!is_bru)
            bru_imm = '0;
        else if (instruction[31:25] == decode_pkg::OPC_PCADDU12I)
            bru_imm = {6'd0, instruction[24:5]};
        else if (major == decode_pkg::OPC_B || major == decode_pkg::OPC_BL)
            bru_imm = {instruction[9:0], instruction[25:10]};   // offs26 split field
        else
            bru_imm = {10'd0, instruction[25:10]};
    end

endmodule

// File: hdl/decode_pkg.sv
package decode_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [31:0] pc_t;
    typedef logic [2:0]  iq_sel_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  alu_op_t;
    typedef logic [2:0]  mdu_op_t;
    typedef logic [3:0]  bru_op_t;
    typedef logic [19:0] alu_imm_t;
    typedef logic [25:0] bru_imm_t;

    localparam iq_sel_t IQ_NONE = 3'b000;
    localparam iq_sel_t IQ_BRU  = 3'b001;
    localparam iq_sel_t IQ_MDU  = 3'b010;
    localparam iq_sel_t IQ_ALU  = 3'b100;

    localparam alu_op_t ALU_LU12I = 5'd0;
    localparam alu_op_t ALU_SLTI  = 5'd1;
    localparam alu_op_t ALU_SLTUI = 5'd2;
    localparam alu_op_t ALU_ADDI  = 5'd3;
    localparam alu_op_t ALU_ANDI  = 5'd4;
    localparam alu_op_t ALU_ORI   = 5'd5;
    localparam alu_op_t ALU_XORI  = 5'd6;
    localparam alu_op_t ALU_ADD   = 5'd7;
    localparam alu_op_t ALU_SUB   = 5'd8;
    localparam alu_op_t ALU_SLT   = 5'd9;
    localparam alu_op_t ALU_SLTU  = 5'd10;
    localparam alu_op_t ALU_NOR   = 5'd11;
    localparam alu_op_t ALU_AND   = 5'd12;
    localparam alu_op_t ALU_OR    = 5'd13;
    localparam alu_op_t ALU_XOR   = 5'd14;
    localparam alu_op_t ALU_SLL   = 5'd15;
    localparam alu_op_t ALU_SRL   = 5'd16;
    localparam alu_op_t ALU_SRA   = 5'd17;
    localparam alu_op_t ALU_SLLI  = 5'd21;
    localparam alu_op_t ALU_SRLI  = 5'd22;
    localparam alu_op_t ALU_SRAI  = 5'd23;

    localparam mdu_op_t MDU_DIV   = 3'd0;
    localparam mdu_op_t MDU_MOD   = 3'd1;
    localparam mdu_op_t MDU_DIVU  = 3'd2;
    localparam mdu_op_t MDU_MODU  = 3'd3;
    localparam mdu_op_t MDU_MUL   = 3'd4;
    localparam mdu_op_t MDU_MULH  = 3'd5;
    localparam mdu_op_t MDU_MULHU = 3'd6;

    localparam bru_op_t BRU_PCADDU = 4'd0;
    localparam bru_op_t BRU_JIRL   = 4'd1;
    localparam bru_op_t BRU_B      = 4'd2;
    localparam bru_op_t BRU_BL     = 4'd3;
    localparam bru_op_t BRU_BEQ    = 4'd4;
    localparam bru_op_t BRU_BNE    = 4'd5;
    localparam bru_op_t BRU_BLT    = 4'd6;
    localparam bru_op_t BRU_BGE    = 4'd7;
    localparam bru_op_t BRU_BLTU   = 4'd8;
    localparam bru_op_t BRU_BGEU   = 4'd9;

    localparam reg_idx_t LINK_REG = 5'd1;

    localparam logic [11:0] OPC_3R        = 12'h001;     // Bits 31:20
    localparam logic [14:0] OPC_DIV       = 15'h0010;    // Bits 31:17
    localparam logic [11:0] OPC_SHIFTI    = 12'h004;     // Bits 31:20, shift select in 19:18
    localparam logic [2:0]  SHIFTI_MINOR  = 3'b001;      // Bits 17:15
    localparam logic [6:0]  OPC_ALUI      = 7'b0000001;  // Bits 31:25
    localparam logic [6:0]  OPC_LU12I     = 7'b0001010;
    localparam logic [6:0]  OPC_PCADDU12I = 7'b0001110;

    // 3R minor field, bits 19:15
    localparam logic [4:0] MIN_ADD   = 5'd0;
    localparam logic [4:0] MIN_SUB   = 5'd2;
    localparam logic [4:0] MIN_SLT   = 5'd4;
    localparam logic [4:0] MIN_SLTU  = 5'd5;
    localparam logic [4:0] MIN_NOR   = 5'd8;
    localparam logic [4:0] MIN_AND   = 5'd9;
    localparam logic [4:0] MIN_OR    = 5'd10;
    localparam logic [4:0] MIN_XOR   = 5'd11;
    localparam logic [4:0] MIN_SLL   = 5'd14;
    localparam logic [4:0] MIN_SRL   = 5'd15;
    localparam logic [4:0] MIN_SRA   = 5'd16;
    localparam logic [4:0] MIN_MUL   = 5'd24;
    localparam logic [4:0] MIN_MULH  = 5'd25;
    localparam logic [4:0] MIN_MULHU = 5'd26;

    // Immediate ALU minor field, bits 24:22
    localparam logic [2:0] ALUI_SLTI  = 3'b000;
    localparam logic [2:0] ALUI_SLTUI = 3'b001;
    localparam logic [2:0] ALUI_ADDI  = 3'b010;
    localparam logic [2:0] ALUI_ANDI  = 3'b101;
    localparam logic [2:0] ALUI_ORI   = 3'b110;
    localparam logic [2:0] ALUI_XORI  = 3'b111;

    localparam logic [1:0] SHIFT_SLL = 2'b00;
    localparam logic [1:0] SHIFT_SRL = 2'b01;
    localparam logic [1:0] SHIFT_SRA = 2'b10;

    // Branch majors, bits 31:26
    localparam logic [5:0] OPC_JIRL = 6'h13;
    localparam logic [5:0] OPC_B    = 6'h14;
    localparam logic [5:0] OPC_BL   = 6'h15;
    localparam logic [5:0] OPC_BEQ  = 6'h16;
    localparam logic [5:0] OPC_BNE  = 6'h17;
    localparam logic [5:0] OPC_BLT  = 6'h18;
    localparam logic [5:0] OPC_BGE  = 6'h19;
    localparam logic [5:0] OPC_BLTU = 6'h1a;
    localparam logic [5:0] OPC_BGEU = 6'h1b;

endpackage

// File: hdl/decode_stage_reg.sv
`timescale 1ns/1ps

module decode_stage_reg (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 hold,
    input  logic                 instruction_vld,
    input  logic                 legal,
    input  logic                 dst_en_dec,
    input  logic                 src1_en_dec,
    input  logic                 src2_en_dec,
    input  decode_pkg::iq_sel_t  iq_sel_dec,
    input  decode_pkg::alu_op_t  alu_op_dec,
    input  decode_pkg::mdu_op_t  mdu_op_dec,
    input  decode_pkg::bru_op_t  bru_op_dec,
    input  decode_pkg::alu_imm_t alu_imm_dec,
    input  decode_pkg::bru_imm_t bru_imm_dec,
    input  decode_pkg::reg_idx_t dst_reg_dec,
    input  decode_pkg::reg_idx_t src1_reg_dec,
    input  decode_pkg::reg_idx_t src2_reg_dec,
    input  decode_pkg::pc_t      pc_in,
    input  decode_pkg::pc_t      target_in,
    output logic                 decode_vld,
    output logic                 ine,
    output decode_pkg::iq_sel_t  iq_sel,
    output decode_pkg::alu_op_t  alu_op,
    output decode_pkg::mdu_op_t  mdu_op,
    output decode_pkg::bru_op_t  bru_op,
    output decode_pkg::alu_imm_t alu_imm,
    output decode_pkg::bru_imm_t bru_imm,
    output logic                 dst_en,
    output logic                 src1_en,
    output logic                 src2_en,
    output decode_pkg::reg_idx_t dst_reg,
    output decode_pkg::reg_idx_t src1_reg,
    output decode_pkg::reg_idx_t src2_reg,
    output decode_pkg::pc_t      pc_out,
    output decode_pkg::pc_t      target_out
);

    logic load;

    assign load = instruction_vld && !flush && !hold;

    // Flush or an empty slot clears, hold keeps everything
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decode_vld <= 1'b0;
            ine        <= 1'b0;
            iq_sel     <= '0;
            alu_op     <= '0;
            mdu_op     <= '0;
            bru_op     <= '0;
            alu_imm    <= '0;
            bru_imm    <= '0;
            dst_en     <= 1'b0;
            src1_en    <= 1'b0;
            src2_en    <= 1'b0;
            dst_reg    <= '0;
            src1_reg   <= '0;
            src2_reg   <= '0;
        end else if (flush || !hold) begin
            decode_vld <= load && legal;
            ine        <= load && !legal;
            iq_sel     <= load ? iq_sel_dec : '0;
            alu_op     <= load ? alu_op_dec : '0;
            mdu_op     <= load ? mdu_op_dec : '0;
            bru_op     <= load ? bru_op_dec : '0;
            alu_imm    <= load ? alu_imm_dec : '0;
            bru_imm    <= load ? bru_imm_dec : '0;
            dst_en     <= load && dst_en_dec;
            src1_en    <= load && src1_en_dec;
            src2_en    <= load && src2_en_dec;
            dst_reg    <= load ? dst_reg_dec : '0;
            src1_reg   <= load ? src1_reg_dec : '0;
            src2_reg   <= load ? src2_reg_dec : '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_out     <= '0;
            target_out <= '0;
        end else if (load) begin
            pc_out     <= pc_in;       // Kept over empty slots
            target_out <= target_in;
        end
    end

endmodule

// File: hdl/decode_top.sv
`timescale 1ns/1ps

module decode_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 hold,
    input  logic                 instruction_vld,
    input  decode_pkg::instr_t   instruction,
    input  decode_pkg::pc_t      pc_in,
    input  decode_pkg::pc_t      target_in,
    output logic                 decode_vld,
    output logic                 ine,
    output decode_pkg::iq_sel_t  iq_sel,
    output decode_pkg::alu_op_t  alu_op,
    output decode_pkg::mdu_op_t  mdu_op,
    output decode_pkg::bru_op_t  bru_op,
    output decode_pkg::alu_imm_t alu_imm,
    output decode_pkg::bru_imm_t bru_imm,
    output logic                 dst_en,
    output logic                 src1_en,
    output logic                 src2_en,
    output decode_pkg::reg_idx_t dst_reg,
    output decode_pkg::reg_idx_t src1_reg,
    output decode_pkg::reg_idx_t src2_reg,
    output decode_pkg::pc_t      pc_out,
    output decode_pkg::pc_t      target_out
);

    decode_pkg::iq_sel_t  iq_sel_dec;
    logic                 legal;
    decode_pkg::alu_op_t  alu_op_dec;
    decode_pkg::mdu_op_t  mdu_op_dec;
    decode_pkg::alu_imm_t alu_imm_dec;
    decode_pkg::bru_op_t  bru_op_dec;
    decode_pkg::bru_imm_t bru_imm_dec;
    logic                 dst_en_dec;
    logic                 src1_en_dec;
    logic                 src2_en_dec;
    decode_pkg::reg_idx_t dst_reg_dec;
    decode_pkg::reg_idx_t src1_reg_dec;
    decode_pkg::reg_idx_t src2_reg_dec;

    iq_classify u_iq_classify (
        .instruction (instruction),
        .iq_sel      (iq_sel_dec),
        .legal       (legal)
    );

    int_op_decode u_int_op_decode (
        .instruction (instruction),
        .iq_sel      (iq_sel_dec),
        .alu_op      (alu_op_dec),
        .mdu_op      (mdu_op_dec),
        .alu_imm     (alu_imm_dec)
    );

    branch_decode u_branch_decode (
        .instruction (instruction),
        .iq_sel      (iq_sel_dec),
        .bru_op      (bru_op_dec),
        .bru_imm     (bru_imm_dec)
    );

    reg_field_decode u_reg_field_decode (
        .instruction (instruction),
        .iq_sel      (iq_sel_dec),
        .dst_en      (dst_en_dec),
        .src1_en     (src1_en_dec),
        .src2_en     (src2_en_dec),
        .dst_reg     (dst_reg_dec),
        .src1_reg    (src1_reg_dec),
        .src2_reg    (src2_reg_dec)
    );

    decode_stage_reg u_decode_stage_reg (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .hold            (hold),
        .instruction_vld (instruction_vld),
        .legal           (legal),
        .dst_en_dec      (dst_en_dec),
        .src1_en_dec     (src1_en_dec),
        .src2_en_dec     (src2_en_dec),
        .iq_sel_dec      (iq_sel_dec),
        .alu_op_dec      (alu_op_dec),
        .mdu_op_dec      (mdu_op_dec),
        .bru_op_dec      (bru_op_dec),
        .alu_imm_dec     (alu_imm_dec),
        .bru_imm_dec     (bru_imm_dec),
        .dst_reg_dec     (dst_reg_dec),
        .src1_reg_dec    (src1_reg_dec),
        .src2_reg_dec    (src2_reg_dec),
        .pc_in           (pc_in),
        .target_in       (target_in),
        .decode_vld      (decode_vld),
        .ine             (ine),
        .iq_sel          (iq_sel),
        .alu_op          (alu_op),
        .mdu_op          (mdu_op),
        .bru_op          (bru_op),
        .alu_imm         (alu_imm),
        .bru_imm         (bru_imm),
        .dst_en          (dst_en),
        .src1_en         (src1_en),
        .src2_en         (src2_en),
        .dst_reg         (dst_reg),
        .src1_reg        (src1_reg),
        .src2_reg        (src2_reg),
        .pc_out          (pc_out),
        .target_out      (target_out)
    );

endmodule

// File: hdl/int_op_decode.sv
`timescale 1ns/1ps

module int_op_decode (
    input  decode_pkg::instr_t   instruction,
    input  decode_pkg::iq_sel_t  iq_sel,
    output decode_pkg::alu_op_t  alu_op,
    output decode_pkg::mdu_op_t  mdu_op,
    output decode_pkg::alu_imm_t alu_imm
);

    logic is_alu;
    logic is_lu12i;

    assign is_alu = (iq_sel == decode_pkg::IQ_ALU);
    assign is_lu12i = (instruction[31:25] == decode_pkg::OPC_LU12I);

    always_comb begin
        alu_op = decode_pkg::ALU_LU12I;                 // LU12I is op 0
        if (is_alu) begin
            if (instruction[31:25] == decode_pkg::OPC_ALUI) begin
                case (instruction[24:22])
                    decode_pkg::ALUI_SLTI:  alu_op = decode_pkg::ALU_SLTI;
                    decode_pkg::ALUI_SLTUI: alu_op = decode_pkg::ALU_SLTUI;
                    decode_pkg::ALUI_ADDI:  alu_op = decode_pkg::ALU_ADDI;
                    decode_pkg::ALUI_ANDI:  alu_op = decode_pkg::ALU_ANDI;
                    decode_pkg::ALUI_ORI:   alu_op = decode_pkg::ALU_ORI;
                    decode_pkg::ALUI_XORI:  alu_op = decode_pkg::ALU_XORI;
                    default:                alu_op = '0;
                endcase
            end else if (instruction[31:20] == decode_pkg::OPC_SHIFTI) begin
                case (instruction[19:18])
                    decode_pkg::SHIFT_SLL: alu_op = decode_pkg::ALU_SLLI;
                    decode_pkg::SHIFT_SRL: alu_op = decode_pkg::ALU_SRLI;
                    decode_pkg::SHIFT_SRA: alu_op = decode_pkg::ALU_SRAI;
                    default:               alu_op = '0;
                endcase
            end else if (instruction[31:20] == decode_pkg::OPC_3R) begin
                case (instruction[19:15])
                    decode_pkg::MIN_ADD:  alu_op = decode_pkg::ALU_ADD;
                    decode_pkg::MIN_SUB:  alu_op = decode_pkg::ALU_SUB;
                    decode_pkg::MIN_SLT:  alu_op = decode_pkg::ALU_SLT;
                    decode_pkg::MIN_SLTU: alu_op = decode_pkg::ALU_SLTU;
                    decode_pkg::MIN_NOR:  alu_op = decode_pkg::ALU_NOR;
                    decode_pkg::MIN_AND:  alu_op = decode_pkg::ALU_AND;
                    decode_pkg::MIN_OR:   alu_op = decode_pkg::ALU_OR;
                    decode_pkg::MIN_XOR:  alu_op = decode_pkg::ALU_XOR;
                    decode_pkg::MIN_SLL:  alu_op = decode_pkg::ALU_SLL;
                    decode_pkg::MIN_SRL:  alu_op = decode_pkg::ALU_SRL;
                    decode_pkg::MIN_SRA:  alu_op = decode_pkg::ALU_SRA;
                    default:              alu_op = '0;
                endcase
            end
        end
    end

    always_comb begin
        mdu_op = '0;
        if (iq_sel == decode_pkg::IQ_MDU) begin
            if (instruction[31:17] == decode_pkg::OPC_DIV) begin
                case (instruction[16:15])
                    2'b00:   mdu_op = decode_pkg::MDU_DIV;
                    2'b01:   mdu_op = decode_pkg::MDU_MOD;
                    2'b10:   mdu_op = decode_pkg::MDU_DIVU;
                    default: mdu_op = decode_pkg::MDU_MODU;
                endcase
            end else begin
                case (instruction[19:15])
                    decode_pkg::MIN_MUL:   mdu_op = decode_pkg::MDU_MUL;
                    decode_pkg::MIN_MULH:  mdu_op = decode_pkg::MDU_MULH;
                    decode_pkg::MIN_MULHU: mdu_op = decode_pkg::MDU_MULHU;
                    default:               mdu_op = '0;
                endcase
            end
        end
    end

    // 20-bit upper immediate for LU12I, si12/ui12/ui5 field otherwise
    assign alu_imm = !is_alu  ? '0 :
                     is_lu12i ? instruction[24:5] : {8'd0, instruction[21:10]};

endmodule

// File: hdl/iq_classify.sv
`timescale 1ns/1ps

module iq_classify (
    input  decode_pkg::instr_t  instruction,
    output decode_pkg::iq_sel_t iq_sel,
    output logic                legal
);

    logic [4:0] minor;
    logic       is_3r;
    logic       is_3r_alu;
    logic       is_mul;
    logic       is_div;
    logic       is_shifti;
    logic       is_alui;
    logic       is_lu12i;
    logic       is_pcaddu;
    logic       is_branch;

    assign minor = instruction[19:15];
    assign is_3r = (instruction[31:20] == decode_pkg::OPC_3R);
    assign is_3r_alu = is_3r && (minor inside {decode_pkg::MIN_ADD, decode_pkg::MIN_SUB,
        decode_pkg::MIN_SLT, decode_pkg::MIN_SLTU, decode_pkg::MIN_NOR, decode_pkg::MIN_AND,
        decode_pkg::MIN_OR, decode_pkg::MIN_XOR, decode_pkg::MIN_SLL, decode_pkg::MIN_SRL,
        decode_pkg::MIN_SRA});
    assign is_mul = is_3r &&
        (minor inside {decode_pkg::MIN_MUL, decode_pkg::MIN_MULH, decode_pkg::MIN_MULHU});
    assign is_div = (instruction[31:17] == decode_pkg::OPC_DIV);
    assign is_shifti = (instruction[31:20] == decode_pkg::OPC_SHIFTI) &&
        (instruction[17:15] == decode_pkg::SHIFTI_MINOR) &&
        (instruction[19:18] != 2'b11);              // 11 is not a shift
    assign is_alui = (instruction[31:25] == decode_pkg::OPC_ALUI) &&
        (instruction[24:22] inside {decode_pkg::ALUI_SLTI, decode_pkg::ALUI_SLTUI,
        decode_pkg::ALUI_ADDI, decode_pkg::ALUI_ANDI, decode_pkg::ALUI_ORI,
        decode_pkg::ALUI_XORI});
    assign is_lu12i = (instruction[31:25] == decode_pkg::OPC_LU12I);
    assign is_pcaddu = (instruction[31:25] == decode_pkg::OPC_PCADDU12I);
    assign is_branch = (instruction[31:26] inside {[decode_pkg::OPC_JIRL:decode_pkg::OPC_BGEU]});

    always_comb begin
        if (is_3r_alu || is_shifti || is_alui || is_lu12i)
            iq_sel = decode_pkg::IQ_ALU;
        else if (is_mul || is_div)
            iq_sel = decode_pkg::IQ_MDU;
        else if (is_branch || is_pcaddu)
            iq_sel = decode_pkg::IQ_BRU;
        else
            iq_sel = decode_pkg::IQ_NONE;
    end

    assign legal = (iq_sel != decode_pkg::IQ_NONE);

endmodule

// File: hdl/reg_field_decode.sv
`timescale 1ns/1ps

module reg_field_decode (
    input  decode_pkg::instr_t   instruction,
    input  decode_pkg::iq_sel_t  iq_sel,
    output logic                 dst_en,
    output logic                 src1_en,
    output logic                 src2_en,
    output decode_pkg::reg_idx_t dst_reg,
    output decode_pkg::reg_idx_t src1_reg,
    output decode_pkg::reg_idx_t src2_reg
);

    logic       is_alu;
    logic       is_mdu;
    logic       is_bru;
    logic [5:0] major;
    logic       is_jirl;
    logic       is_bl;
    logic       is_pcaddu;
    logic       is_cond;
    logic       is_lu12i;
    logic       is_3r;

    assign is_alu = (iq_sel == decode_pkg::IQ_ALU);
    assign is_mdu = (iq_sel == decode_pkg::IQ_MDU);
    assign is_bru = (iq_sel == decode_pkg::IQ_BRU);
    assign major = instruction[31:26];

    assign is_jirl = is_bru && (major == decode_pkg::OPC_JIRL);
    assign is_bl = is_bru && (major == decode_pkg::OPC_BL);
    assign is_pcaddu = is_bru && (instruction[31:25] == decode_pkg::OPC_PCADDU12I);
    assign is_cond = is_bru && (major inside {[decode_pkg::OPC_BEQ:decode_pkg::OPC_BGEU]});
    assign is_lu12i = is_alu && (instruction[31:25] == decode_pkg::OPC_LU12I);
    assign is_3r = is_alu && (instruction[31:20] == decode_pkg::OPC_3R);

    assign dst_reg = is_bl ? decode_pkg::LINK_REG : instruction[4:0];
    assign src1_reg = instruction[9:5];
    assign src2_reg = is_cond ? instruction[4:0] : instruction[14:10];  // Compare against rd

    assign dst_en = is_alu || is_mdu || is_jirl || is_bl || is_pcaddu;
    assign src1_en = (is_alu && !is_lu12i) || is_mdu || is_jirl || is_cond;
    assign src2_en = is_3r || is_mdu || is_cond;

endmodule

// File: sim.f
hdl/decode_pkg.sv
hdl/iq_classify.sv
hdl/int_op_decode.sv
hdl/branch_decode.sv
hdl/reg_field_decode.sv
hdl/decode_stage_reg.sv
hdl/decode_top.sv
test/decode_properties.sv
test/decode_tb.sv

// File: test/decode_properties.sv
`timescale 1ns/1ps

module decode_properties (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 flush,
    input logic                 hold,
    input logic                 decode_vld,
    input logic                 ine,
    input decode_pkg::iq_sel_t  iq_sel,
    input decode_pkg::alu_op_t  alu_op,
    input decode_pkg::mdu_op_t  mdu_op,
    input decode_pkg::bru_op_t  bru_op,
    input decode_pkg::alu_imm_t alu_imm,
    input decode_pkg::bru_imm_t bru_imm,
    input logic                 dst_en,
    input logic                 src1_en,
    input logic                 src2_en,
    input decode_pkg::reg_idx_t dst_reg,
    input decode_pkg::reg_idx_t src1_reg,
    input decode_pkg::reg_idx_t src2_reg,
    input decode_pkg::pc_t      pc_out,
    input decode_pkg::pc_t      target_out
);

    logic [144:0] outs;                               // Every registered output

    assign outs = {decode_vld, ine, iq_sel, alu_op, mdu_op, bru_op, alu_imm, bru_imm,
                   dst_en, src1_en, src2_en, dst_reg, src1_reg, src2_reg, pc_out, target_out};

    iq_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(iq_sel))
        else $error("iq_sel has more than one queue bit set");

    vld_ine_excl: assert property (@(posedge clk) disable iff (!rst_n) !(decode_vld && ine))
        else $error("decode_vld and ine set together");

    flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> (!decode_vld && iq_sel == decode_pkg::IQ_NONE))
        else $error("outputs not cleared after flush");

    hold_keeps: assert property (@(posedge clk) disable iff (!rst_n)
        (hold && !flush) |=> $stable(outs))
        else $error("outputs changed during hold");

endmodule

bind decode_top decode_properties u_properties (.*);

// File: test/decode_tb.sv
`timescale 1ns/1ps

module decode_tb;

    localparam int DIRECTED_CYCLES = 60;
    localparam int RAND_CYCLES = 380;
    localparam int MAX_CYCLES = 4 * (16 + DIRECTED_CYCLES + RAND_CYCLES);  // ~4x margin

    // 3R minor fields in ALU op order, then immediate ALU minors
    localparam logic [4:0] M3R [0:10] = '{5'd0, 5'd2, 5'd4, 5'd5, 5'd8, 5'd9, 5'd10,
                                          5'd11, 5'd14, 5'd15, 5'd16};
    localparam logic [2:0] MALUI [0:5] = '{3'd0, 3'd1, 3'd2, 3'd5, 3'd6, 3'd7};

    logic                 clk;
    logic                 rst_n;
    logic                 flush;
    logic                 hold;
    logic                 instruction_vld;
    decode_pkg::instr_t   instruction;
    decode_pkg::pc_t      pc_in;
    decode_pkg::pc_t      target_in;
    logic                 decode_vld;
    logic                 ine;
    decode_pkg::iq_sel_t  iq_sel;
    decode_pkg::alu_op_t  alu_op;
    decode_pkg::mdu_op_t  mdu_op;
    decode_pkg::bru_op_t  bru_op;
    decode_pkg::alu_imm_t alu_imm;
    decode_pkg::bru_imm_t bru_imm;
    logic                 dst_en;
    logic                 src1_en;
    logic                 src2_en;
    decode_pkg::reg_idx_t dst_reg;
    decode_pkg::reg_idx_t src1_reg;
    decode_pkg::reg_idx_t src2_reg;
    decode_pkg::pc_t      pc_out;
    decode_pkg::pc_t      target_out;

    int                   seed;
    int                   cycle_count = 0;
    int                   k;
    logic [31:0]          rnd;
    string                test_name;
    decode_pkg::instr_t   instr;

    // Decoded values of the current instruction, then the registered prediction
    decode_pkg::iq_sel_t  d_iq, e_iq;
    decode_pkg::alu_op_t  d_alu, e_alu;
    decode_pkg::mdu_op_t  d_mdu, e_mdu;
    decode_pkg::bru_op_t  d_bru, e_bru;
    decode_pkg::alu_imm_t d_aimm, e_aimm;
    decode_pkg::bru_imm_t d_bimm, e_bimm;
    logic [2:0]           d_en, e_en;                // dst, src1, src2
    decode_pkg::reg_idx_t d_dst, d_src1, d_src2, e_dst, e_src1, e_src2;
    logic                 e_vld, e_ine;
    decode_pkg::pc_t      e_pc, e_tgt;

    decode_top u_dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
            abort_run($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input string field, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else
            abort_run($sformatf("error %s: %s expected %0h actual %0h",
                                test_name, field, exp, act));
    endtask

    // Instruction kinds 0-20 ALU, 21-27 MDU, 28-37 branch, 38-41 illegal
    task automatic build(input int kind);
        instr = $random(seed);
        {d_iq, d_alu, d_mdu, d_bru, d_aimm, d_bimm, d_en} = '0;
        if (kind < 11) begin
            instr[31:15] = {12'h001, M3R[kind]};
            d_iq = decode_pkg::IQ_ALU;
            d_alu = 5'(kind + 7);
            d_en = 3'b111;
        end else if (kind < 17) begin
            instr[31:22] = {7'b0000001, MALUI[kind - 11]};
            d_iq = decode_pkg::IQ_ALU;
            d_alu = 5'(kind - 10);
            d_en = 3'b110;
        end else if (kind < 20) begin
            instr[31:15] = {12'h004, 2'(kind - 17), 3'b001};
            d_iq = decode_pkg::IQ_ALU;
            d_alu = 5'(kind + 4);                     // SLLI 21 onwards
            d_en = 3'b110;
        end else if (kind == 20) begin
            instr[31:25] = 7'b0001010;                // LU12I.W
            d_iq = decode_pkg::IQ_ALU;
            d_en = 3'b100;
        end else if (kind < 24) begin
            instr[31:15] = {12'h001, 5'(kind + 3)};   // MUL, MULH, MULHU
            d_iq = decode_pkg::IQ_MDU;
            d_mdu = 3'(kind - 17);
            d_en = 3'b111;
        end else if (kind < 28) begin
            instr[31:15] = {15'h0010, 2'(kind - 24)};
            d_iq = decode_pkg::IQ_MDU;
            d_mdu = 3'(kind - 24);
            d_en = 3'b111;
        end else if (kind < 37) begin
            instr[31:26] = 6'(kind - 9);              // Majors 0x13 to 0x1b
            d_iq = decode_pkg::IQ_BRU;
            d_bru = 4'(kind - 27);
            d_en = (kind == 28) ? 3'b110 : (kind == 29) ? 3'b000 :
                   (kind == 30) ? 3'b100 : 3'b011;
        end else if (kind == 37) begin
            instr[31:25] = 7'b0001110;                // PCADDU12I
            d_iq = decode_pkg::IQ_BRU;
            d_en = 3'b100;
        end else if (kind == 38) begin
            instr[31:15] = {12'h001, 5'd1};
        end else if (kind == 39) begin
            instr[31:22] = {7'b0000001, 3'b011};
        end else if (kind == 40) begin
            instr[31:15] = {12'h004, 2'b11, 3'b001};
        end else begin
            instr[31:26] = 6'h3f;
        end
        d_dst = (kind == 30) ? decode_pkg::LINK_REG : instr[4:0];
        d_src1 = instr[9:5];
        d_src2 = (kind > 30 && kind < 37) ? instr[4:0] : instr[14:10];
        if (d_iq == decode_pkg::IQ_ALU)
            d_aimm = (kind == 20) ? instr[24:5] : {8'd0, instr[21:10]};
        if (d_iq == decode_pkg::IQ_BRU)
            d_bimm = (kind == 37) ? {6'd0, instr[24:5]} :
                     (kind == 29 || kind == 30) ? {instr[9:0], instr[25:10]} :
                     {10'd0, instr[25:10]};
    endtask

    // Every DUT output against the model
    task automatic compare_outputs();
        check("decode_vld", 32'(e_vld), 32'(decode_vld));
        check("ine", 32'(e_ine), 32'(ine));
        check("iq_sel", 32'(e_iq), 32'(iq_sel));
        check("alu_op", 32'(e_alu), 32'(alu_op));
        check("mdu_op", 32'(e_mdu), 32'(mdu_op));
        check("bru_op", 32'(e_bru), 32'(bru_op));
        check("alu_imm", 32'(e_aimm), 32'(alu_imm));
        check("bru_imm", 32'(e_bimm), 32'(bru_imm));
        check("enables", 32'(e_en), 32'({dst_en, src1_en, src2_en}));
        check("dst_reg", 32'(e_dst), 32'(dst_reg));
        check("src1_reg", 32'(e_src1), 32'(src1_reg));
        check("src2_reg", 32'(e_src2), 32'(src2_reg));
        check("pc_out", e_pc, pc_out);
        check("target_out", e_tgt, target_out);
    endtask

    // Drive one cycle, update the stage model, compare after the edge
    task automatic run_cycle(input logic vld, input logic fl, input logic hd);
        logic load;
        instruction = instr;
        instruction_vld = vld;
        flush = fl;
        hold = hd;
        pc_in = $random(seed);
        target_in = $random(seed);
        @(negedge clk);
        load = vld && !fl && !hd;
        if (fl || !hd) begin
            e_vld = load && (d_iq != decode_pkg::IQ_NONE);
            e_ine = load && (d_iq == decode_pkg::IQ_NONE);
            {e_iq, e_alu, e_mdu, e_bru, e_aimm, e_bimm, e_en, e_dst, e_src1, e_src2} =
                load ? {d_iq, d_alu, d_mdu, d_bru, d_aimm, d_bimm, d_en, d_dst, d_src1, d_src2}
                     : '0;
        end
        if (load) begin
            e_pc = pc_in;
            e_tgt = target_in;
        end
        compare_outputs();
    endtask

    initial begin
        seed = 32'hedcb_f0aa;
        clk = 1'b0;
        rst_n = 1'b0;
        {flush, hold, instruction_vld, instruction, pc_in, target_in} = '0;
        instr = '0;
        {d_iq, d_alu, d_mdu, d_bru, d_aimm, d_bimm, d_en, d_dst, d_src1, d_src2} = '0;
        {e_vld, e_ine, e_iq, e_alu, e_mdu, e_bru, e_aimm, e_bimm, e_en} = '0;
        {e_dst, e_src1, e_src2, e_pc, e_tgt} = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        test_name = "reset";
        compare_outputs();                            // Reset values before any edge
        rst_n = 1'b1;

        run_cycle(1'b0, 1'b0, 1'b0);
        run_cycle(1'b0, 1'b0, 1'b0);
        test_name = "alu";
        for (k = 0; k < 21; k++) begin
            build(k);
            run_cycle(1'b1, 1'b0, 1'b0);
        end
        test_name = "mdu";
        for (k = 21; k < 28; k++) begin
            build(k);
            run_cycle(1'b1, 1'b0, 1'b0);
        end
        test_name = "branch";
        for (k = 28; k < 38; k++) begin
            build(k);
            run_cycle(1'b1, 1'b0, 1'b0);
        end
        test_name = "illegal";
        for (k = 38; k < 42; k++) begin
            build(k);
            run_cycle(1'b1, 1'b0, 1'b0);
        end
        test_name = "idle";
        run_cycle(1'b0, 1'b0, 1'b0);                  // pc_out must survive

        test_name = "hold";
        build(3);
        run_cycle(1'b1, 1'b0, 1'b0);
        repeat (4) begin
            build(28);
            run_cycle(1'b1, 1'b0, 1'b1);
        end
        test_name = "flush";
        build(30);
        run_cycle(1'b1, 1'b1, 1'b1);                  // Flush wins over hold
        build(5);
        run_cycle(1'b1, 1'b0, 1'b0);
        build(22);
        run_cycle(1'b1, 1'b1, 1'b0);

        test_name = "random";
        repeat (RAND_CYCLES) begin
            rnd = $random(seed);
            build(int'(rnd[7:0]) % 42);
            run_cycle(rnd[8] | rnd[9], rnd[15:13] == 3'd0, rnd[12:10] == 3'd0);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
